/* project.f */
pdp11_pkg.sv
pdp11_decode.sv
pdp11_regfile.sv
pdp11_ea.sv
pdp11_execute.sv
pdp11_control.sv
pdp11_core.sv
pdp11_checker.sv
tb_pdp11.sv

/* run.sh */
#!/usr/bin/env bash
# build the core and testbench with verilator, run, then check the log
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_pdp11 -f project.f -o tb_pdp11_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_pdp11_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
fi

if [ $status -eq 0 ] && grep -q "All tests passed" "$log"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1

/* tb_pdp11.sv */
// testbench for the word-only pdp-11 core
// memory model with optional random acknowledge stalls, program rom
// result table applied in a loop, value check and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_pdp11
   import pdp11_pkg::*;
();

   localparam int          mem_words    = 4096;
   localparam int          max_rows     = 32;
   localparam int          reset_cycles = 16;
   localparam int          row_cycles   = 2000;
   localparam logic [31:0] ack_seed     = 32'haf99b641;

   logic        clk = 1'b0;
   logic        reset_n;
   logic        bus_ack = 1'b0;
   logic [15:0] bus_addr;
   logic [15:0] bus_wdata;
   logic [15:0] bus_rdata;
   logic        bus_rd;
   logic        bus_wr;
   logic        halted;

   logic [15:0] mem   [0:mem_words-1];
   logic [15:0] image [0:mem_words-1];   // next program image copied in during reset
   logic        load_en;
   logic        stall_on;
   logic [31:0] rng = ack_seed;

   int          row_prog  [max_rows];
   logic        row_stall [max_rows];
   logic [15:0] row_addr  [max_rows];
   logic [15:0] row_value [max_rows];
   logic        row_halt  [max_rows];
   int          n_rows = 0;

   // all programs start at reset_pc
   logic [15:0] rom [0:54] = '{
      16'o012737, 16'h1234, 16'o001000,     // mov #1234, @#1000
      16'o062737, 16'hf00f, 16'o001000,     // add #f00f, @#1000
      16'o162737, 16'h0345, 16'o001002,     // sub #0345, @#1002
      16'o000000,
      // loop and branches
      16'o012700, 16'o000005,               // mov #5, r0
      16'o005001,                           // clr r1
      16'o005201,                           // inc r1 at the loop top
      16'o005300,                           // dec r0
      16'o001375,                           // bne back 3 words
      16'o010137, 16'o001000,               // mov r1, @#1000
      16'o022701, 16'o000005,               // cmp #5, r1
      16'o001402,                           // beq over the clr
      16'o005037, 16'o001002,               // clr @#1002
      16'o005237, 16'o001004,               // inc @#1004
      16'o005737, 16'o001006,               // tst @#1006
      16'o001002,                           // bne not taken
      16'o005037, 16'o001010,               // clr @#1010
      16'o000000,
      // block copy and deferred modes
      16'o012700, 16'o001100,               // mov #1100, r0
      16'o012701, 16'o001210,               // mov #1210, r1
      16'o012041,                           // mov (r0)+, -(r1)
      16'o012041,
      16'o012702, 16'o001300,               // mov #1300, r2
      16'o012703, 16'o001322,               // mov #1322, r3
      16'o013253,                           // mov @(r2)+, @-(r3)
      16'o010037, 16'o001600,               // mov r0, @#1600
      16'o000000,
      // illegal byte op
      16'o012737, 16'h4321, 16'o001000,
      16'o112737, 16'o000377, 16'o001002,   // movb
      16'o012737, 16'h7777, 16'o001004,
      16'o000000
   };
   int prog_first [0:4] = '{0, 10, 31, 45, 55};

   pdp11_core dut0 (
      .clk, .reset_n, .bus_addr, .bus_wdata, .bus_rd, .bus_wr, .halted,
      .bus_rdata, .bus_ack
   );

   bind pdp11_core pdp11_checker checker0 (
      .clk, .reset_n, .bus_addr, .bus_rd, .bus_wr, .bus_ack, .halted
   );

   always #20 clk = ~clk;

   assign bus_rdata = mem[bus_addr[12:1]];   // combinational read

   always @(posedge clk)
   begin
      if (load_en)
      begin
         for (int i = 0; i < mem_words; i++)
            mem[i] <= image[i];
      end
      else if (bus_wr && bus_ack)
         mem[bus_addr[12:1]] <= bus_wdata;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   always @(posedge clk)
   begin
      #2;
      if (stall_on)
      begin
         rng = xorshift32(rng);
         bus_ack <= rng[7];       // high about half the time
      end
      else
         bus_ack <= 1'b1;
   end

   function automatic logic [15:0] fill_word(input logic [15:0] addr);
      return {4'h6, addr[12:1]} ^ 16'h0a5a;
   endfunction

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
      if (got !== expected)
         fail_run($sformatf("CHECK FAILED %s got %04h expected %04h", name, got, expected));
   endtask

   task automatic add_row(input int prog, input logic [15:0] addr,
                          input logic [15:0] value, input logic halt);
      row_prog[n_rows]  = prog;
      row_stall[n_rows] = 1'b0;
      row_addr[n_rows]  = addr;
      row_value[n_rows] = value;
      row_halt[n_rows]  = halt;
      n_rows++;
   endtask

   task automatic build_table();
      int base;
      add_row(0, 16'o001000, 16'h1234 + 16'hf00f, 1'b1);
      add_row(0, 16'o001002, 16'h0100 - 16'h0345, 1'b1);
      add_row(1, 16'o001000, 16'd5, 1'b1);                    // loop count
      add_row(1, 16'o001002, fill_word(16'o001002), 1'b1);    // clr skipped
      add_row(1, 16'o001004, 16'h0100, 1'b1);
      add_row(1, 16'o001010, 16'h0000, 1'b1);
      add_row(2, 16'o001206, 16'h1111, 1'b1);
      add_row(2, 16'o001204, 16'h2222, 1'b1);
      add_row(2, 16'o001500, 16'h3333, 1'b1);
      add_row(2, 16'o001600, 16'o001104, 1'b1);               // r0 after two steps
      add_row(3, 16'o001000, 16'h4321, 1'b1);
      add_row(3, 16'o001002, fill_word(16'o001002), 1'b1);
      add_row(3, 16'o001004, fill_word(16'o001004), 1'b1);
      base = n_rows;
      // same rows again under random stalls
      for (int r = 0; r < base; r++)
      begin
         add_row(row_prog[r], row_addr[r], row_value[r], row_halt[r]);
         row_stall[n_rows - 1] = 1'b1;
      end
   endtask

   task automatic preset(input logic [15:0] addr, input logic [15:0] value);
      image[addr[12:1]] = value;
   endtask

   task automatic load_program(input int prog);
      int at;
      for (int i = 0; i < mem_words; i++)
         image[i] = fill_word(16'(i * 2));
      at = int'(reset_pc[12:1]);
      for (int i = prog_first[prog]; i < prog_first[prog + 1]; i++)
      begin
         image[at] = rom[i];
         at++;
      end
      case (prog)
         0: preset(16'o001002, 16'h0100);
         1:
         begin
            preset(16'o001004, 16'h00ff);
            preset(16'o001006, 16'h0000);
            preset(16'o001010, 16'h5555);
         end
         2:
         begin
            preset(16'o001100, 16'h1111);
            preset(16'o001102, 16'h2222);
            preset(16'o001300, 16'o001400);   // source pointer
            preset(16'o001400, 16'h3333);
            preset(16'o001320, 16'o001500);   // destination pointer
         end
         default: ;
      endcase
   endtask

   task automatic run_row(input int r);
      int waited;
      load_program(row_prog[r]);
      stall_on = row_stall[r];
      @(posedge clk);
      #2;
      reset_n = 1'b0;
      load_en = 1'b1;
      repeat (reset_cycles)
      begin
         @(posedge clk);
         #2;
         load_en = 1'b0;
      end
      reset_n = 1'b1;
      #1;
      // first fetch right out of reset
      check_value("bus_rd", 16'(bus_rd), 16'h0001);
      check_value("bus_addr", bus_addr, reset_pc);
      check_value("bus_wr", 16'(bus_wr), 16'h0000);
      check_value("halted", 16'(halted), 16'h0000);
      waited = 0;
      while (!halted && waited < row_cycles)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      check_value("halted", 16'(halted), 16'(row_halt[r]));
      check_value($sformatf("mem[%06o]", row_addr[r]), mem[row_addr[r][12:1]], row_value[r]);
   endtask

   initial
   begin
      reset_n  = 1'b0;
      load_en  = 1'b0;
      stall_on = 1'b0;
      build_table();
      for (int r = 0; r < n_rows; r++)
         run_row(r);
      $display("All tests passed");
      $finish;
   end

   initial
   begin
      @(posedge clk);
      repeat (n_rows * (row_cycles + reset_cycles + 2)) @(posedge clk);
      fail_run("watchdog timeout, the core did not halt in time");
   end

endmodule

`default_nettype wire

/* pdp11_checker.sv */
// concurrent assertions on the memory bus strobes and address
// and on the quiet bus after halt
`timescale 1ns/1ns
`default_nettype none

module pdp11_checker
   import pdp11_pkg::*;
(
   input logic              clk,
   input logic              reset_n,
   input logic [word_w-1:0] bus_addr,
   input logic              bus_rd,
   input logic              bus_wr,
   input logic              bus_ack,
   input logic              halted
);

   strobes_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
      !(bus_rd && bus_wr))
      else $error("bus_rd and bus_wr high in the same cycle");

   // no bus traffic once stopped
   quiet_when_halted: assert property (@(posedge clk) disable iff (!reset_n)
      halted |-> !bus_rd && !bus_wr)
      else $error("bus strobe high while halted");

   word_aligned: assert property (@(posedge clk) disable iff (!reset_n)
      (bus_rd || bus_wr) |-> !bus_addr[0])
      else $error("odd bus address with a strobe high");

   read_held: assert property (@(posedge clk) disable iff (!reset_n)
      bus_rd && !bus_ack |=> bus_rd && $stable(bus_addr))
      else $error("read dropped or moved before acknowledge");

   write_held: assert property (@(posedge clk) disable iff (!reset_n)
      bus_wr && !bus_ack |=> bus_wr && $stable(bus_addr))
      else $error("write dropped or moved before acknowledge");

endmodule

`default_nettype wire

/* pdp11_core.sv */
// top level of the word-only pdp-11 core
// connects decode, registers, ea, execute and sequencer to the memory bus
`timescale 1ns/1ns
`default_nettype none

module pdp11_core
   import pdp11_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   output logic [word_w-1:0] bus_addr,
   output logic [word_w-1:0] bus_wdata,
   output logic              bus_rd,
   output logic              bus_wr,
   output logic              halted,
   input  logic [word_w-1:0] bus_rdata,
   input  logic              bus_ack
);

   istate_t           istate;
   opcode_t           opcode;
   logic [2:0]        ss_mode, ss_reg, dd_mode, dd_reg;
   logic [7:0]        branch_offset;
   logic              need_src, need_dst, need_dst_data, store_result;
   logic [word_w-1:0] ss_value, dd_value, pc;
   logic [word_w-1:0] ss_ea, dd_ea, ss_data, dd_data;
   logic [word_w-1:0] result, new_pc;
   logic [3:0]        new_cc, cc;
   logic              latch_cc, latch_pc, halt_req;

   pdp11_decode decode0 (
      .clk, .reset_n, .istate, .bus_ack, .bus_rdata, .opcode,
      .ss_mode, .ss_reg, .dd_mode, .dd_reg, .branch_offset,
      .need_src, .need_dst, .need_dst_data, .store_result
   );

   pdp11_regfile regfile0 (
      .clk, .reset_n, .istate, .bus_ack, .ss_mode, .ss_reg, .dd_mode, .dd_reg,
      .need_src, .need_dst, .store_result, .latch_pc, .halting(halted),
      .new_pc, .result, .ss_value, .dd_value, .pc
   );

   pdp11_ea ea0 (
      .clk, .reset_n, .istate, .bus_ack, .ss_mode, .dd_mode,
      .ss_value, .dd_value, .bus_rdata, .ss_ea, .dd_ea, .ss_data, .dd_data
   );

   pdp11_execute execute0 (
      .opcode, .ss_data, .dd_data, .pc, .branch_offset, .cc,
      .result, .new_pc, .new_cc, .latch_cc, .latch_pc, .halt_req
   );

   pdp11_control control0 (
      .clk, .reset_n, .bus_ack, .opcode, .ss_mode, .dd_mode,
      .need_src, .need_dst, .need_dst_data, .store_result,
      .latch_cc, .halt_req, .new_cc, .pc, .ss_ea, .dd_ea, .result,
      .istate, .cc, .bus_addr, .bus_wdata, .bus_rd, .bus_wr, .halted
   );

endmodule

`default_nettype wire

/* pdp11_control.sv */
// state sequencer with next-state logic
// bus strobes and address, psw condition codes and the halted flag
`timescale 1ns/1ns
`default_nettype none

module pdp11_control
   import pdp11_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              bus_ack,
   input  opcode_t           opcode,
   input  logic [2:0]        ss_mode,
   input  logic [2:0]        dd_mode,
   input  logic              need_src,
   input  logic              need_dst,
   input  logic              need_dst_data,
   input  logic              store_result,
   input  logic              latch_cc,
   input  logic              halt_req,
   input  logic [3:0]        new_cc,
   input  logic [word_w-1:0] pc,
   input  logic [word_w-1:0] ss_ea,
   input  logic [word_w-1:0] dd_ea,
   input  logic [word_w-1:0] result,
   output istate_t           istate,
   output logic [3:0]        cc,
   output logic [word_w-1:0] bus_addr,
   output logic [word_w-1:0] bus_wdata,
   output logic              bus_rd,
   output logic              bus_wr,
   output logic              halted
);

   istate_t next_state;
   logic    ss_deferred;
   logic    dd_deferred;

   assign ss_deferred = ss_mode == mode_incdef || ss_mode == mode_decdef;
   assign dd_deferred = dd_mode == mode_incdef || dd_mode == mode_decdef;

   always_comb
   begin
      next_state = istate;
      case (istate)
         f1: next_state = c1;
         c1:
            if (opcode == op_bad)
               next_state = e1;      // straight to the halt
            else if (need_src)
               next_state = s1;
            else if (need_dst)
               next_state = d1;
            else
               next_state = e1;
         s1:
            if (ss_deferred)
               next_state = s2;
            else if (ss_mode != mode_reg)
               next_state = s4;
            else
               next_state = d1;
         s2: next_state = s4;
         s4: next_state = d1;
         d1:
            if (dd_deferred)
               next_state = d2;
            else if (dd_mode != mode_reg && need_dst_data)
               next_state = d4;
            else
               next_state = e1;
         d2: next_state = need_dst_data ? d4 : e1;
         d4: next_state = e1;
         e1:
            if (halt_req)
               next_state = h1;
            else if (store_result)
               next_state = w1;
            else
               next_state = f1;      // branches, cmp, tst
         w1: next_state = f1;
         default: next_state = h1;
      endcase
   end

   // every state waits for an acknowledge
   always_ff @(posedge clk)
      if (!reset_n)
      begin
         istate <= f1;
         cc     <= '0;
         halted <= 1'b0;
      end
      else if (bus_ack)
      begin
         istate <= next_state;
         if (istate == e1 && latch_cc)
            cc <= new_cc;
         if (istate == e1 && halt_req)
            halted <= 1'b1;
      end

   always_comb
   begin
      bus_rd   = 1'b0;
      bus_wr   = 1'b0;
      bus_addr = pc;
      case (istate)
         f1: bus_rd = 1'b1;
         s2, s4:
         begin
            bus_rd   = 1'b1;
            bus_addr = ss_ea;
         end
         d2, d4:
         begin
            bus_rd   = 1'b1;
            bus_addr = dd_ea;
         end
         w1:
         begin
            bus_wr   = store_result && dd_mode != mode_reg;   // memory destination
            bus_addr = dd_ea;
         end
         default: ;
      endcase
   end

   assign bus_wdata = result;

endmodule

`default_nettype wire

/* pdp11_execute.sv */
// combinational execute unit for state e1
// word alu result, new n/z/v/c and branch target
`timescale 1ns/1ns
`default_nettype none

module pdp11_execute
   import pdp11_pkg::*;
(
   input  opcode_t           opcode,
   input  logic [word_w-1:0] ss_data,
   input  logic [word_w-1:0] dd_data,
   input  logic [word_w-1:0] pc,
   input  logic [7:0]        branch_offset,
   input  logic [3:0]        cc,
   output logic [word_w-1:0] result,
   output logic [word_w-1:0] new_pc,
   output logic [3:0]        new_cc,
   output logic              latch_cc,
   output logic              latch_pc,
   output logic              halt_req
);

   logic [word_w:0]   sum;       // top bit is carry or borrow
   logic [word_w-1:0] br_disp;
   logic              ss_sign;
   logic              dd_sign;
   logic              v;
   logic              c;

   assign ss_sign = ss_data[word_w-1];
   assign dd_sign = dd_data[word_w-1];

   always_comb
   begin
      sum      = '0;
      result   = dd_data;
      v        = 1'b0;
      c        = cc[0];      // kept unless the op says otherwise
      latch_cc = 1'b1;
      latch_pc = 1'b0;
      halt_req = 1'b0;
      case (opcode)
         op_mov: result = ss_data;
         op_cmp:
         begin
            sum    = {1'b0, ss_data} - {1'b0, dd_data};    // src - dst
            result = sum[word_w-1:0];
            v      = (ss_sign != dd_sign) && (result[word_w-1] == dd_sign);
            c      = sum[word_w];
         end
         op_add:
         begin
            sum    = {1'b0, ss_data} + {1'b0, dd_data};
            result = sum[word_w-1:0];
            v      = (ss_sign == dd_sign) && (result[word_w-1] != ss_sign);
            c      = sum[word_w];
         end
         op_sub:
         begin
            sum    = {1'b0, dd_data} - {1'b0, ss_data};    // dst - src
            result = sum[word_w-1:0];
            v      = (ss_sign != dd_sign) && (result[word_w-1] == ss_sign);
            c      = sum[word_w];
         end
         op_clr:
         begin
            result = '0;
            c      = 1'b0;
         end
         op_inc:
         begin
            result = dd_data + word_w'(1);
            v      = dd_data == 16'o077777;
         end
         op_dec:
         begin
            result = dd_data - word_w'(1);
            v      = dd_data == 16'o100000;
         end
         op_tst: c = 1'b0;
         op_br:
         begin
            latch_cc = 1'b0;
            latch_pc = 1'b1;
         end
         op_bne:
         begin
            latch_cc = 1'b0;
            latch_pc = !cc[2];
         end
         op_beq:
         begin
            latch_cc = 1'b0;
            latch_pc = cc[2];
         end
         default:              // halt and illegal
         begin
            latch_cc = 1'b0;
            halt_req = 1'b1;
         end
      endcase
   end

   assign new_cc = {result[word_w-1], result == '0, v, c};

   // pc already points past the branch word
   assign br_disp = {{(word_w-9){branch_offset[7]}}, branch_offset, 1'b0};
   assign new_pc  = pc + br_disp;

endmodule

`default_nettype wire

/* pdp11_ea.sv */
// source and destination effective-address registers
// operand data registers loaded from a register or from the bus
`timescale 1ns/1ns
`default_nettype none

module pdp11_ea
   import pdp11_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  istate_t           istate,
   input  logic              bus_ack,
   input  logic [2:0]        ss_mode,
   input  logic [2:0]        dd_mode,
   input  logic [word_w-1:0] ss_value,
   input  logic [word_w-1:0] dd_value,
   input  logic [word_w-1:0] bus_rdata,
   output logic [word_w-1:0] ss_ea,
   output logic [word_w-1:0] dd_ea,
   output logic [word_w-1:0] ss_data,
   output logic [word_w-1:0] dd_data
);

   // address formed in s1/d1, before any pointer fetch
   function automatic logic [word_w-1:0] first_ea(input logic [2:0] mode,
                                                  input logic [word_w-1:0] value);
      case (mode)
         mode_def, mode_inc, mode_incdef: return value;
         mode_dec, mode_decdef:           return value - word_w'(2);
         default:                         return value;
      endcase
   endfunction

   function automatic logic deferred(input logic [2:0] mode);
      return mode == mode_incdef || mode == mode_decdef;
   endfunction

   always_ff @(posedge clk)
      if (!reset_n)
      begin
         ss_ea   <= '0;
         dd_ea   <= '0;
         ss_data <= '0;
         dd_data <= '0;
      end
      else if (bus_ack)
      begin
         case (istate)
            c1:
            begin
               if (ss_mode == mode_reg)
                  ss_data <= ss_value;
               if (dd_mode == mode_reg)
                  dd_data <= dd_value;
            end
            s1: ss_ea <= first_ea(ss_mode, ss_value);
            s2: if (deferred(ss_mode)) ss_ea <= bus_rdata;   // pointer word
            s4: ss_data <= bus_rdata;
            d1: dd_ea <= first_ea(dd_mode, dd_value);
            d2: if (deferred(dd_mode)) dd_ea <= bus_rdata;
            d4: dd_data <= bus_rdata;
            default: ;
         endcase
      end

endmodule

`default_nettype wire

/* pdp11_regfile.sv */
// general registers r0-r7, pc advance and branch load
// auto-increment / auto-decrement side effects and register writeback
`timescale 1ns/1ns
`default_nettype none

module pdp11_regfile
   import pdp11_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  istate_t           istate,
   input  logic              bus_ack,
   input  logic [2:0]        ss_mode,
   input  logic [2:0]        ss_reg,
   input  logic [2:0]        dd_mode,
   input  logic [2:0]        dd_reg,
   input  logic              need_src,
   input  logic              need_dst,
   input  logic              store_result,
   input  logic              latch_pc,
   input  logic              halting,
   input  logic [word_w-1:0] new_pc,
   input  logic [word_w-1:0] result,
   output logic [word_w-1:0] ss_value,
   output logic [word_w-1:0] dd_value,
   output logic [word_w-1:0] pc
);

   logic [word_w-1:0] regs [0:7];
   logic              step;

   // register value after the mode side effect
   function automatic logic [word_w-1:0] auto_step(input logic [2:0] mode,
                                                   input logic [word_w-1:0] value);
      if (mode == mode_inc || mode == mode_incdef)
         return value + word_w'(2);
      else if (mode == mode_dec || mode == mode_decdef)
         return value - word_w'(2);
      return value;
   endfunction

   assign step = bus_ack && !halting;   // frozen once stopped

   assign ss_value = regs[ss_reg];
   assign dd_value = regs[dd_reg];
   assign pc       = regs[reg_pc];

   always_ff @(posedge clk)
      if (!reset_n)
      begin
         for (int i = 0; i < 8; i++)
            regs[i] <= (3'(i) == reg_pc) ? reset_pc : '0;
      end
      else if (step)
      begin
         case (istate)
            f1: regs[reg_pc] <= regs[reg_pc] + word_w'(2);
            s1: if (need_src) regs[ss_reg] <= auto_step(ss_mode, regs[ss_reg]);
            d1: if (need_dst) regs[dd_reg] <= auto_step(dd_mode, regs[dd_reg]);
            e1: if (latch_pc) regs[reg_pc] <= new_pc;   // taken branch
            w1:
               if (store_result && dd_mode == mode_reg)
               begin
                  // pc and sp stay word aligned
                  if (dd_reg == reg_pc || dd_reg == reg_sp)
                     regs[dd_reg] <= {result[word_w-1:1], 1'b0};
                  else
                     regs[dd_reg] <= result;
               end
            default: ;
         endcase
      end

endmodule

`default_nettype wire

/* pdp11_decode.sv */
// instruction register and decode
// classifies the latched word into an opcode and derives the need flags
`timescale 1ns/1ns
`default_nettype none

module pdp11_decode
   import pdp11_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  istate_t           istate,
   input  logic              bus_ack,
   input  logic [word_w-1:0] bus_rdata,
   output opcode_t           opcode,
   output logic [2:0]        ss_mode,
   output logic [2:0]        ss_reg,
   output logic [2:0]        dd_mode,
   output logic [2:0]        dd_reg,
   output logic [7:0]        branch_offset,
   output logic              need_src,
   output logic              need_dst,
   output logic              need_dst_data,
   output logic              store_result
);

   logic [word_w-1:0] isn;
   logic [3:0]        isn_15_12;
   logic [7:0]        isn_15_8;
   logic [9:0]        isn_15_6;
   logic              ss_ok;
   logic              dd_ok;

   always_ff @(posedge clk)
      if (!reset_n)
         isn <= '0;
      else if (istate == f1 && bus_ack)
         isn <= bus_rdata;    // word at pc

   assign isn_15_12 = isn[15:12];
   assign isn_15_8  = isn[15:8];
   assign isn_15_6  = isn[15:6];

   assign ss_mode       = isn[11:9];
   assign ss_reg        = isn[8:6];
   assign dd_mode       = isn[5:3];
   assign dd_reg        = isn[2:0];
   assign branch_offset = isn[7:0];

   // no index modes in this core
   assign ss_ok = ss_mode <= mode_decdef;
   assign dd_ok = dd_mode <= mode_decdef;

   always_comb
   begin
      if (isn == '0)
         opcode = op_halt;
      else if (isn_15_8 == 8'o001)
         opcode = op_br;
      else if (isn_15_8 == 8'o002)
         opcode = op_bne;
      else if (isn_15_8 == 8'o003)
         opcode = op_beq;
      else if (isn_15_6 == 10'o0050 && dd_ok)
         opcode = op_clr;
      else if (isn_15_6 == 10'o0052 && dd_ok)
         opcode = op_inc;
      else if (isn_15_6 == 10'o0053 && dd_ok)
         opcode = op_dec;
      else if (isn_15_6 == 10'o0057 && dd_ok)
         opcode = op_tst;
      else if (ss_ok && dd_ok && isn_15_12 == 4'o01)
         opcode = op_mov;
      else if (ss_ok && dd_ok && isn_15_12 == 4'o02)
         opcode = op_cmp;
      else if (ss_ok && dd_ok && isn_15_12 == 4'o06)
         opcode = op_add;
      else if (ss_ok && dd_ok && isn_15_12 == 4'o16)
         opcode = op_sub;
      else
         opcode = op_bad;     // byte forms land here too
   end

   // double operand: mov-add and sub
   assign need_src = (isn_15_12 >= 4'o01 && isn_15_12 <= 4'o06) || isn_15_12 == 4'o16;

   // single operand clr-asl as well
   assign need_dst = need_src || (isn_15_6 >= 10'o0050 && isn_15_6 <= 10'o0063);

   assign need_dst_data = !(isn_15_12 == 4'o01) &&    // mov
                          !(isn_15_6 == 10'o0050);    // clr

   assign store_result = need_dst &&
                         !(isn_15_12 == 4'o02) &&     // cmp
                         !(isn_15_12 == 4'o03) &&     // bit
                         !(isn_15_6 == 10'o0057);     // tst

endmodule

`default_nettype wire

/* pdp11_pkg.sv */
// shared widths, reset pc and register numbers
// fsm states, opcodes and addressing mode numbers for the word-only core
`default_nettype none

package pdp11_pkg;

   localparam int word_w = 16;

   localparam logic [word_w-1:0] reset_pc = 16'o000500;

   // register numbers with a fixed role
   localparam logic [2:0] reg_pc = 3'd7;
   localparam logic [2:0] reg_sp = 3'd6;

   // addressing modes, index modes 6 and 7 not supported
   localparam logic [2:0] mode_reg    = 3'd0;   // R
   localparam logic [2:0] mode_def    = 3'd1;   // (R)
   localparam logic [2:0] mode_inc    = 3'd2;   // (R)+
   localparam logic [2:0] mode_incdef = 3'd3;   // @(R)+
   localparam logic [2:0] mode_dec    = 3'd4;   // -(R)
   localparam logic [2:0] mode_decdef = 3'd5;   // @-(R)

   // h1 halt, f1 fetch, c1 decode, s* source, d* dest, e1 execute, w1 writeback
   typedef enum logic [3:0] {
      h1,
      f1,
      c1,
      s1,
      s2,
      s4,
      d1,
      d2,
      d4,
      e1,
      w1
   } istate_t;

   typedef enum logic [3:0] {
      op_mov,
      op_cmp,
      op_add,
      op_sub,
      op_clr,
      op_inc,
      op_dec,
      op_tst,
      op_br,
      op_bne,
      op_beq,
      op_halt,
      op_bad    // anything else, stops the core
   } opcode_t;

endpackage

`default_nettype wire
